// ==== src/drs_pkg.sv ====
package drs_pkg;

  // ----------------------------------------------------------------------
  // data widths
  // ----------------------------------------------------------------------

  // 14 bit adc sample
  typedef logic [13:0] adc_word_t;

  // chip address bus a3..a0
  typedef logic [3:0] chip_addr_t;

  // channel number 0..8, 8 is the reference channel
  typedef logic [3:0] chan_t;

  // readout mask, bit 8 is the reference channel
  typedef logic [8:0] chan_mask_t;

  // image of the config or write shift register
  typedef logic [7:0] sr_word_t;

  typedef logic [9:0]  sample_count_t;
  typedef logic [15:0] settle_count_t;
  typedef logic [5:0]  latency_t;

  // ----------------------------------------------------------------------
  // sequencer states
  // ----------------------------------------------------------------------

  typedef enum logic [3:0] {
    INIT          = 4'd0,
    IDLE          = 4'd1,
    CONF          = 4'd2,
    WSR           = 4'd3,
    START_RUNNING = 4'd4,
    RUNNING       = 4'd5,
    WAIT_VDD      = 4'd6,
    READOUT       = 4'd7,
    STANDBY       = 4'd8
  } seq_state_t;

  // ----------------------------------------------------------------------
  // chip addresses, from the drs4 datasheet
  // ----------------------------------------------------------------------

  localparam chip_addr_t ADR_READ_SR  = 4'b1011;
  localparam chip_addr_t ADR_WRITE_SR = 4'b1101;
  localparam chip_addr_t ADR_CONFIG   = 4'b1100;
  localparam chip_addr_t ADR_STANDBY  = 4'b1111;

  // config bits 7..3 are reserved and must be written as 1
  localparam sr_word_t CONFIG_FORCED_ONES = 8'hf8;

  // nreset low time, datasheet minimum
  localparam int RESET_HOLD_CYCLES = 2;
  // about 1.5 domino revolutions before triggers are armed
  localparam int DOMINO_WARMUP_CYCLES = 105;

  localparam chan_t REF_CHANNEL = 4'd8;

endpackage

// ==== src/drs_if.sv ====
`timescale 1ns/1ps

// ----------------------------------------------------------------------
// sequencer to serializer
// ----------------------------------------------------------------------

interface drs_shift_if import drs_pkg::*; ();
  // one cycle load strobe with the word to send
  logic     load;
  sr_word_t word;
  // serial bit and its clock enable
  logic     srin;
  logic     shifting;
  // high on the last bit
  logic     done;

  modport master (output load, output word, input srin, input shifting, input done);
  modport slave  (input load, input word, output srin, output shifting, output done);
endinterface

// ----------------------------------------------------------------------
// sequencer to channel scan
// ----------------------------------------------------------------------

interface drs_scan_if import drs_pkg::*; ();
  logic  arm;
  logic  advance;
  chan_t chan;
  // no enabled channel above the current one
  logic  is_last;

  modport master (output arm, output advance, input chan, input is_last);
  modport slave  (input arm, input advance, output chan, output is_last);
endinterface

// ----------------------------------------------------------------------
// sequencer to sample gate
// ----------------------------------------------------------------------

interface drs_gate_if ();
  logic start;
  logic srclk_req;
  logic chan_done;

  modport master (output start, input srclk_req, input chan_done);
  modport slave  (input start, output srclk_req, output chan_done);
endinterface

// ==== src/drs_sequencer.sv ====
`timescale 1ns/1ps

module drs_sequencer import drs_pkg::*; (
  input  logic          clock,
  input  logic          reset,
  input  logic          trigger_i,
  // 1 continuous domino, 0 single shot
  input  logic          dmode_i,
  input  logic          start_i,
  input  logic          reinit_i,
  input  logic          configure_i,
  input  logic          standby_i,
  input  sr_word_t      config_i,
  input  sr_word_t      chn_config_i,
  input  settle_count_t wait_vdd_clocks_i,
  input  logic          mask_any_i,
  drs_shift_if.master   shift,
  drs_scan_if.master    scan,
  drs_gate_if.master    gate,
  output chip_addr_t    drs_addr_o,
  output logic          drs_nreset_o,
  output logic          drs_denable_o,
  output logic          drs_dwrite_o,
  output logic          drs_srclk_en_o,
  output logic          drs_srin_o,
  output logic          drs_on_o,
  output logic          busy_o,
  output logic          readout_complete_o
);

  seq_state_t    state;
  // init hold and supply settle share this counter
  settle_count_t wait_count;
  settle_count_t warm_count;
  logic          reinit_req;
  logic          trig_q;
  logic          trig_accept;

  // registered trigger, or free running in single shot
  assign trig_accept = mask_any_i && (trig_q || !dmode_i);

  // ----------------------------------------------------------------------
  // pin decode
  // ----------------------------------------------------------------------

  assign drs_nreset_o = (state != INIT);
  assign drs_on_o     = (state != STANDBY);

  always_comb begin
    drs_addr_o     = ADR_READ_SR;
    drs_srclk_en_o = 1'b0;
    drs_srin_o     = 1'b0;
    case (state)
      INIT, STANDBY: drs_addr_o = ADR_STANDBY;
      CONF: begin
        drs_addr_o     = ADR_CONFIG;
        drs_srclk_en_o = shift.shifting;
        drs_srin_o     = shift.srin;
      end
      WSR: begin
        drs_addr_o     = ADR_WRITE_SR;
        drs_srclk_en_o = shift.shifting;
        drs_srin_o     = shift.srin;
      end
      // address follows the scan through the whole channel
      READOUT: begin
        drs_addr_o     = scan.chan;
        drs_srclk_en_o = gate.srclk_req;
      end
      default: ;
    endcase
  end

  // ----------------------------------------------------------------------
  // state machine
  // ----------------------------------------------------------------------

  always_ff @(posedge clock) begin
    if (reset) begin
      state              <= INIT;
      wait_count         <= '0;
      warm_count         <= '0;
      reinit_req         <= 1'b0;
      trig_q             <= 1'b0;
      drs_denable_o      <= 1'b0;
      drs_dwrite_o       <= 1'b0;
      busy_o             <= 1'b0;
      readout_complete_o <= 1'b0;
      shift.load         <= 1'b0;
      scan.arm           <= 1'b0;
      scan.advance       <= 1'b0;
      gate.start         <= 1'b0;
    end else begin
      // strobes default low
      shift.load         <= 1'b0;
      scan.arm           <= 1'b0;
      scan.advance       <= 1'b0;
      gate.start         <= 1'b0;
      readout_complete_o <= 1'b0;

      // reinit is a pulse, hold it until INIT
      reinit_req <= reinit_req | reinit_i;
      trig_q     <= trigger_i & mask_any_i & (state == RUNNING);

      if (state != INIT && state != WAIT_VDD) begin
        wait_count <= '0;
      end

      case (state)
        INIT: begin
          drs_denable_o <= 1'b0;
          drs_dwrite_o  <= 1'b0;
          busy_o        <= 1'b0;
          reinit_req    <= 1'b0;
          if (wait_count == settle_count_t'(RESET_HOLD_CYCLES - 1)) begin
            state <= IDLE;
          end else begin
            wait_count <= wait_count + 1'b1;
          end
        end

        IDLE: begin
          warm_count <= '0;
          if (reinit_req) begin
            state <= INIT;
          end else if (standby_i) begin
            state <= STANDBY;
          end else if (configure_i) begin
            // config register first, then the write shift register
            state      <= CONF;
            shift.load <= 1'b1;
            shift.word <= config_i | CONFIG_FORCED_ONES;
          end else if (start_i) begin
            state         <= START_RUNNING;
            busy_o        <= 1'b1;
            drs_denable_o <= 1'b1;
            drs_dwrite_o  <= 1'b1;
          end
        end

        CONF: begin
          if (shift.done) begin
            state      <= WSR;
            shift.load <= 1'b1;
            shift.word <= chn_config_i;
          end
        end

        WSR: begin
          if (shift.done) begin
            state <= IDLE;
          end
        end

        // domino runs but triggers stay blocked
        START_RUNNING: begin
          if (reinit_req) begin
            state <= INIT;
          end else if (warm_count == settle_count_t'(DOMINO_WARMUP_CYCLES)) begin
            state <= RUNNING;
          end else begin
            warm_count <= warm_count + 1'b1;
          end
        end

        RUNNING: begin
          if (reinit_req) begin
            state <= INIT;
          end else if (standby_i) begin
            state         <= IDLE;
            busy_o        <= 1'b0;
            drs_denable_o <= 1'b0;
            drs_dwrite_o  <= 1'b0;
          end else if (trig_accept) begin
            // freeze the sampling cells
            state        <= WAIT_VDD;
            drs_dwrite_o <= 1'b0;
            scan.arm     <= 1'b1;
          end
        end

        // let the analog supply settle after the stop
        WAIT_VDD: begin
          if (reinit_req) begin
            state      <= INIT;
            wait_count <= '0;
          end else if (wait_count == wait_vdd_clocks_i) begin
            state      <= READOUT;
            gate.start <= 1'b1;
          end else begin
            wait_count <= wait_count + 1'b1;
          end
        end

        READOUT: begin
          if (reinit_req) begin
            state <= INIT;
          end else if (gate.chan_done) begin
            if (scan.is_last) begin
              state              <= IDLE;
              busy_o             <= 1'b0;
              readout_complete_o <= 1'b1;
            end else begin
              scan.advance <= 1'b1;
              gate.start   <= 1'b1;
            end
          end
        end

        STANDBY: begin
          if (!standby_i) begin
            state <= IDLE;
          end
        end

        default: state <= INIT;
      endcase
    end
  end

endmodule

// ==== src/drs_serializer.sv ====
`timescale 1ns/1ps

module drs_serializer import drs_pkg::*; (
  input  logic       clock,
  input  logic       reset,
  drs_shift_if.slave shift
);

  // ----------------------------------------------------------------------
  // msb first shift out of one register image
  // ----------------------------------------------------------------------

  sr_word_t sreg;
  // wraps to zero after the last bit
  logic [$clog2($bits(sr_word_t))-1:0] bit_count;
  logic     shifting;

  assign shift.shifting = shifting;
  // keep srin quiet between words
  assign shift.srin     = shifting & sreg[$high(sreg)];
  assign shift.done     = shifting & (&bit_count);

  // data path
  always_ff @(posedge clock) begin
    if (shift.load) begin
      sreg <= shift.word;
    end else if (shifting) begin
      sreg <= {sreg[$high(sreg)-1:0], 1'b0};
    end
  end

  // bit counter and busy level
  always_ff @(posedge clock) begin
    if (reset) begin
      shifting  <= 1'b0;
      bit_count <= '0;
    end else if (shift.load) begin
      shifting  <= 1'b1;
      bit_count <= '0;
    end else if (shifting) begin
      bit_count <= bit_count + 1'b1;
      // last bit on the wire this cycle
      if (&bit_count) begin
        shifting <= 1'b0;
      end
    end
  end

endmodule

// ==== src/drs_channel_scan.sv ====
`timescale 1ns/1ps

module drs_channel_scan import drs_pkg::*; (
  input  logic       clock,
  input  logic       reset,
  input  chan_mask_t mask_i,
  drs_scan_if.slave  scan
);

  // ----------------------------------------------------------------------
  // ascending walk over the enabled channels
  // ----------------------------------------------------------------------

  // channels still to be read
  chan_mask_t pending;
  // pending without the current channel
  chan_mask_t remaining;
  chan_t      chan_sel;

  // lowest set bit wins, loop runs downward
  always_comb begin
    chan_sel = REF_CHANNEL;
    for (int i = REF_CHANNEL; i >= 0; i--) begin
      if (pending[i]) begin
        chan_sel = chan_t'(i);
      end
    end
  end

  assign remaining = pending & ~(chan_mask_t'(1) << chan_sel);

  // nothing left above the current channel
  assign scan.is_last = (remaining == '0);
  assign scan.chan    = chan_sel;

  always_ff @(posedge clock) begin
    if (reset) begin
      pending <= '0;
    end else if (scan.arm) begin
      // snapshot at trigger time
      pending <= mask_i;
    end else if (scan.advance) begin
      pending <= remaining;
    end
  end

endmodule

// ==== src/drs_sample_gate.sv ====
`timescale 1ns/1ps

module drs_sample_gate import drs_pkg::*; (
  input  logic          clock,
  input  logic          reset,
  input  adc_word_t     adc_data_i,
  input  sample_count_t sample_count_max_i,
  input  latency_t      adc_latency_i,
  drs_gate_if.slave     gate,
  output adc_word_t     fifo_wdata_o,
  output logic          fifo_wen_o
);

  adc_word_t     adc_q;
  logic          active;
  // read clocks issued in this channel
  sample_count_t rd_count;
  // words written in this channel
  sample_count_t sample_count;
  logic          write_now;
  logic          last_word;

  // ----------------------------------------------------------------------
  // read clock request and fifo write qualifier
  // ----------------------------------------------------------------------

  assign gate.srclk_req = active && (rd_count < sample_count_max_i);
  // adc pipeline has caught up with the first read clock
  assign write_now      = active && (rd_count > adc_latency_i);
  assign last_word      = (sample_count == sample_count_max_i - 1'b1);

  // ----------------------------------------------------------------------
  // data path
  // ----------------------------------------------------------------------

  // input register, adc and fpga share the clock
  always_ff @(posedge clock) begin
    adc_q <= adc_data_i;
    if (write_now) begin
      fifo_wdata_o <= adc_q;
    end
  end

  // ----------------------------------------------------------------------
  // counters
  // ----------------------------------------------------------------------

  always_ff @(posedge clock) begin
    if (reset) begin
      active         <= 1'b0;
      rd_count       <= '0;
      sample_count   <= '0;
      fifo_wen_o     <= 1'b0;
      gate.chan_done <= 1'b0;
    end else begin
      fifo_wen_o     <= write_now;
      // flagged together with the final word
      gate.chan_done <= write_now && last_word;
      if (gate.start) begin
        active       <= 1'b1;
        rd_count     <= '0;
        sample_count <= '0;
      end else if (active) begin
        // stops at max, or just past the latency if that is longer
        if (gate.srclk_req || rd_count <= adc_latency_i) begin
          rd_count <= rd_count + 1'b1;
        end
        if (write_now) begin
          sample_count <= sample_count + 1'b1;
          if (last_word) begin
            active <= 1'b0;
          end
        end
      end
    end
  end

endmodule

// ==== src/drs_readout.sv ====
`timescale 1ns/1ps

module drs_readout import drs_pkg::*; (
  input  logic          clock,
  input  logic          reset,
  input  logic          trigger_i,
  input  adc_word_t     adc_data_i,

  // control
  input  logic          dmode_i,
  input  logic          start_i,
  input  logic          reinit_i,
  input  logic          configure_i,
  input  logic          standby_i,
  input  sr_word_t      config_i,
  input  sr_word_t      chn_config_i,
  input  settle_count_t wait_vdd_clocks_i,
  input  sample_count_t sample_count_max_i,
  input  latency_t      adc_latency_i,
  // channels 0..7, reference channel added below
  input  logic [7:0]    readout_mask_i,

  // chip pins
  output chip_addr_t    drs_addr_o,
  output logic          drs_nreset_o,
  output logic          drs_denable_o,
  output logic          drs_dwrite_o,
  output logic          drs_srclk_en_o,
  output logic          drs_srin_o,
  output logic          drs_on_o,

  // fifo and status
  output adc_word_t     fifo_wdata_o,
  output logic          fifo_wen_o,
  output logic          busy_o,
  output logic          readout_complete_o
);

  // ----------------------------------------------------------------------
  // internal buses
  // ----------------------------------------------------------------------

  drs_shift_if shift_bus ();
  drs_scan_if  scan_bus ();
  drs_gate_if  gate_bus ();

  // channel 8 rides along whenever any channel is on
  chan_mask_t scan_mask;
  assign scan_mask = {|readout_mask_i, readout_mask_i};

  drs_sequencer u_sequencer (
    .clock              (clock),
    .reset              (reset),
    .trigger_i          (trigger_i),
    .dmode_i            (dmode_i),
    .start_i            (start_i),
    .reinit_i           (reinit_i),
    .configure_i        (configure_i),
    .standby_i          (standby_i),
    .config_i           (config_i),
    .chn_config_i       (chn_config_i),
    .wait_vdd_clocks_i  (wait_vdd_clocks_i),
    .mask_any_i         (|scan_mask),
    .shift              (shift_bus.master),
    .scan               (scan_bus.master),
    .gate               (gate_bus.master),
    .drs_addr_o         (drs_addr_o),
    .drs_nreset_o       (drs_nreset_o),
    .drs_denable_o      (drs_denable_o),
    .drs_dwrite_o       (drs_dwrite_o),
    .drs_srclk_en_o     (drs_srclk_en_o),
    .drs_srin_o         (drs_srin_o),
    .drs_on_o           (drs_on_o),
    .busy_o             (busy_o),
    .readout_complete_o (readout_complete_o)
  );

  drs_serializer u_serializer (
    .clock (clock),
    .reset (reset),
    .shift (shift_bus.slave)
  );

  drs_channel_scan u_channel_scan (
    .clock  (clock),
    .reset  (reset),
    .mask_i (scan_mask),
    .scan   (scan_bus.slave)
  );

  // fifo outputs come straight from here
  drs_sample_gate u_sample_gate (
    .clock              (clock),
    .reset              (reset),
    .adc_data_i         (adc_data_i),
    .sample_count_max_i (sample_count_max_i),
    .adc_latency_i      (adc_latency_i),
    .gate               (gate_bus.slave),
    .fifo_wdata_o       (fifo_wdata_o),
    .fifo_wen_o         (fifo_wen_o)
  );

endmodule

// ==== test/drs_readout_assert.sv ====
`timescale 1ns/1ps

module drs_readout_assert import drs_pkg::*; (
  input logic       clock,
  input logic       reset,
  input logic       fifo_wen_i,
  input chip_addr_t addr_i,
  input logic       on_i,
  input logic       complete_i
);

  // ----------------------------------------------------------------------
  // output protocol rules
  // ----------------------------------------------------------------------

  // fifo writes only while a channel is addressed
  a_wen_addr: assert property (
    @(posedge clock) disable iff (reset) fifo_wen_i |-> (addr_i <= REF_CHANNEL)
  ) else $error("fifo write while drs_addr_o is not a channel");

  // single cycle strobe
  a_complete_pulse: assert property (
    @(posedge clock) disable iff (reset) complete_i |=> !complete_i
  ) else $error("readout_complete_o high for more than one cycle");

  // chip powered down only at the standby address
  a_standby_addr: assert property (
    @(posedge clock) disable iff (reset) !on_i |-> (addr_i == ADR_STANDBY)
  ) else $error("drs_on_o low with drs_addr_o not at standby");

endmodule

bind drs_readout drs_readout_assert u_assert (
  .clock      (clock),
  .reset      (reset),
  .fifo_wen_i (fifo_wen_o),
  .addr_i     (drs_addr_o),
  .on_i       (drs_on_o),
  .complete_i (readout_complete_o)
);

// ==== test/tb_drs_readout.sv ====
`timescale 1ns/1ps

module tb_drs_readout import drs_pkg::*; ();

  localparam int            CLOCK_PERIOD   = 10;
  localparam int            TIMEOUT_CYCLES = 2000;
  localparam sample_count_t SAMPLE_MAX     = 10'd12;
  localparam latency_t      ADC_LATENCY    = 6'd3;
  localparam settle_count_t SETTLE_CLOCKS  = 16'd5;

  logic          clock;
  logic          reset;
  logic          trigger_i;
  adc_word_t     adc_data_i;
  logic          dmode_i;
  logic          start_i;
  logic          reinit_i;
  logic          configure_i;
  logic          standby_i;
  sr_word_t      config_i;
  sr_word_t      chn_config_i;
  settle_count_t wait_vdd_clocks_i;
  sample_count_t sample_count_max_i;
  latency_t      adc_latency_i;
  logic [7:0]    readout_mask_i;
  chip_addr_t    drs_addr_o;
  logic          drs_nreset_o;
  logic          drs_denable_o;
  logic          drs_dwrite_o;
  logic          drs_srclk_en_o;
  logic          drs_srin_o;
  logic          drs_on_o;
  adc_word_t     fifo_wdata_o;
  logic          fifo_wen_o;
  logic          busy_o;
  logic          readout_complete_o;

  // adc model state, hist[0] is the word now on the pins
  logic [31:0] rng_state;
  adc_word_t   adc_hist [2];
  // drs_addr_o seen with every fifo write
  chan_t       fifo_chan_q [$];
  // drs_addr_o seen with every read clock
  chan_t       srclk_chan_q [$];

  drs_readout UUT (
    .clock              (clock),
    .reset              (reset),
    .trigger_i          (trigger_i),
    .adc_data_i         (adc_data_i),
    .dmode_i            (dmode_i),
    .start_i            (start_i),
    .reinit_i           (reinit_i),
    .configure_i        (configure_i),
    .standby_i          (standby_i),
    .config_i           (config_i),
    .chn_config_i       (chn_config_i),
    .wait_vdd_clocks_i  (wait_vdd_clocks_i),
    .sample_count_max_i (sample_count_max_i),
    .adc_latency_i      (adc_latency_i),
    .readout_mask_i     (readout_mask_i),
    .drs_addr_o         (drs_addr_o),
    .drs_nreset_o       (drs_nreset_o),
    .drs_denable_o      (drs_denable_o),
    .drs_dwrite_o       (drs_dwrite_o),
    .drs_srclk_en_o     (drs_srclk_en_o),
    .drs_srin_o         (drs_srin_o),
    .drs_on_o           (drs_on_o),
    .fifo_wdata_o       (fifo_wdata_o),
    .fifo_wen_o         (fifo_wen_o),
    .busy_o             (busy_o),
    .readout_complete_o (readout_complete_o)
  );

  initial begin
    clock = 1'b0;
    forever #(CLOCK_PERIOD / 2) clock = ~clock;
  end

  // ----------------------------------------------------------------------
  // helpers
  // ----------------------------------------------------------------------

  task automatic stop_on_error(input string why);
    $display("tests failed");
    $fatal(1, "%s", why);
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
      stop_on_error({"wrong value on ", name});
    end
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // sample point and drive point, 1 ns past the edge
  task automatic next_cycle();
    @(posedge clock);
    #1;
  endtask

  task automatic check_idle_outputs();
    check_value("drs_addr_o", drs_addr_o, ADR_READ_SR);
    check_value("drs_nreset_o", drs_nreset_o, 1'b1);
    check_value("drs_denable_o", drs_denable_o, 1'b0);
    check_value("drs_dwrite_o", drs_dwrite_o, 1'b0);
    check_value("drs_srclk_en_o", drs_srclk_en_o, 1'b0);
    check_value("drs_srin_o", drs_srin_o, 1'b0);
    check_value("drs_on_o", drs_on_o, 1'b1);
    check_value("fifo_wen_o", fifo_wen_o, 1'b0);
    check_value("busy_o", busy_o, 1'b0);
    check_value("readout_complete_o", readout_complete_o, 1'b0);
  endtask

  task automatic wait_readout_complete();
    int n;
    n = 0;
    while (!readout_complete_o) begin
      n++;
      if (n > TIMEOUT_CYCLES) begin
        stop_on_error("readout_complete_o did not pulse in time");
      end
      next_cycle();
    end
  endtask

  // ascending channels, SAMPLE_MAX words and read clocks each
  task automatic check_fifo_channels(input logic [8:0] chan_set);
    int idx;
    idx = 0;
    for (int c = 0; c < 9; c++) begin
      if (chan_set[c]) begin
        for (int k = 0; k < int'(SAMPLE_MAX); k++) begin
          if (idx >= fifo_chan_q.size() || idx >= srclk_chan_q.size()) begin
            stop_on_error("fewer FIFO words or read clocks than expected");
          end
          check_value("drs_addr_o during fifo_wen_o", fifo_chan_q[idx], c);
          check_value("drs_addr_o during drs_srclk_en_o", srclk_chan_q[idx], c);
          idx++;
        end
      end
    end
    check_value("fifo word count", fifo_chan_q.size(), idx);
    check_value("read clock count", srclk_chan_q.size(), idx);
  endtask

  task automatic pulse_start();
    start_i = 1'b1;
    next_cycle();
    start_i = 1'b0;
  endtask

  // ----------------------------------------------------------------------
  // adc model and fifo monitor
  // ----------------------------------------------------------------------

  // fifo word is the adc word from two edges back
  always begin
    next_cycle();
    if (fifo_wen_o) begin
      check_value("fifo_wdata_o", fifo_wdata_o, adc_hist[1]);
      fifo_chan_q.push_back(drs_addr_o);
    end
    // read clocks only happen at a channel address
    if (drs_srclk_en_o && drs_addr_o <= REF_CHANNEL) begin
      srclk_chan_q.push_back(drs_addr_o);
    end
    adc_hist[1] = adc_hist[0];
    rng_state   = xorshift32(rng_state);
    adc_hist[0] = rng_state[13:0];
    adc_data_i  = adc_hist[0];
  end

  // ----------------------------------------------------------------------
  // tests
  // ----------------------------------------------------------------------

  task automatic test_reset();
    int low_cycles;
    low_cycles = 0;
    check_value("drs_addr_o", drs_addr_o, ADR_STANDBY);
    check_value("drs_on_o", drs_on_o, 1'b1);
    check_value("busy_o", busy_o, 1'b0);
    check_value("fifo_wen_o", fifo_wen_o, 1'b0);
    while (!drs_nreset_o) begin
      low_cycles++;
      if (low_cycles > TIMEOUT_CYCLES) begin
        stop_on_error("drs_nreset_o never rose after reset");
      end
      next_cycle();
    end
    check_value("drs_nreset_o low cycles", low_cycles, RESET_HOLD_CYCLES);
    check_idle_outputs();
  endtask

  task automatic test_configure();
    logic [15:0] bits;
    int          count;
    int          cycle;
    int          run_start;
    chip_addr_t  exp_addr;
    count        = 0;
    cycle        = 0;
    run_start    = 0;
    config_i     = 8'h15;
    chn_config_i = 8'ha6;
    configure_i  = 1'b1;
    next_cycle();
    configure_i = 1'b0;
    while (count < 16) begin
      if (drs_srclk_en_o) begin
        exp_addr = (count < 8) ? ADR_CONFIG : ADR_WRITE_SR;
        check_value("drs_addr_o", drs_addr_o, exp_addr);
        if (count % 8 == 0) begin
          run_start = cycle;
        end
        // eight back to back shift cycles per word
        if (count % 8 == 7) begin
          check_value("drs_srclk_en_o run length", cycle - run_start + 1, 8);
        end
        bits[15 - count] = drs_srin_o;
        count++;
      end
      cycle++;
      if (cycle > TIMEOUT_CYCLES) begin
        stop_on_error("serial register write did not finish");
      end
      next_cycle();
    end
    check_value("config bits", bits[15:8], 8'h15 | CONFIG_FORCED_ONES);
    check_value("write sr bits", bits[7:0], 8'ha6);
    check_idle_outputs();
  endtask

  task automatic test_triggered_readout();
    int n;
    n              = 0;
    readout_mask_i = 8'b0000_0101;
    dmode_i        = 1'b1;
    trigger_i      = 1'b1;
    fifo_chan_q.delete();
    srclk_chan_q.delete();
    pulse_start();
    check_value("busy_o", busy_o, 1'b1);
    check_value("drs_denable_o", drs_denable_o, 1'b1);
    // trigger held, so the stop lands right after warm-up
    while (drs_dwrite_o) begin
      n++;
      if (n > TIMEOUT_CYCLES) begin
        stop_on_error("trigger was never accepted");
      end
      next_cycle();
    end
    // warm-up, then one cycle to register the trigger and one to accept it
    check_value("cycles from start to stop", n, DOMINO_WARMUP_CYCLES + 3);
    trigger_i = 1'b0;
    wait_readout_complete();
    check_value("busy_o", busy_o, 1'b0);
    check_fifo_channels(9'b1_0000_0101);
    for (int k = 0; k < 20; k++) begin
      next_cycle();
      check_value("readout_complete_o", readout_complete_o, 1'b0);
      check_value("fifo_wen_o", fifo_wen_o, 1'b0);
    end
  endtask

  task automatic test_single_shot();
    readout_mask_i = 8'b0000_0010;
    dmode_i        = 1'b0;
    trigger_i      = 1'b0;
    fifo_chan_q.delete();
    srclk_chan_q.delete();
    pulse_start();
    wait_readout_complete();
    check_value("busy_o", busy_o, 1'b0);
    check_fifo_channels(9'b1_0000_0010);
  endtask

  task automatic test_zero_mask();
    int n;
    n              = 0;
    readout_mask_i = 8'b0;
    dmode_i        = 1'b1;
    trigger_i      = 1'b1;
    pulse_start();
    for (int k = 0; k < 300; k++) begin
      check_value("drs_dwrite_o", drs_dwrite_o, 1'b1);
      check_value("fifo_wen_o", fifo_wen_o, 1'b0);
      check_value("readout_complete_o", readout_complete_o, 1'b0);
      next_cycle();
    end
    // standby from RUNNING drops back to idle
    trigger_i = 1'b0;
    standby_i = 1'b1;
    next_cycle();
    standby_i = 1'b0;
    while (busy_o) begin
      n++;
      if (n > TIMEOUT_CYCLES) begin
        stop_on_error("busy_o stayed high after standby in running");
      end
      next_cycle();
    end
    check_idle_outputs();
  endtask

  task automatic test_standby();
    int n;
    n         = 0;
    standby_i = 1'b1;
    while (drs_on_o) begin
      n++;
      if (n > TIMEOUT_CYCLES) begin
        stop_on_error("drs_on_o did not fall in standby");
      end
      next_cycle();
    end
    for (int k = 0; k < 10; k++) begin
      check_value("drs_on_o", drs_on_o, 1'b0);
      check_value("drs_addr_o", drs_addr_o, ADR_STANDBY);
      next_cycle();
    end
    standby_i = 1'b0;
    n         = 0;
    while (!drs_on_o) begin
      n++;
      if (n > TIMEOUT_CYCLES) begin
        stop_on_error("drs_on_o did not return after standby release");
      end
      next_cycle();
    end
    check_idle_outputs();
  endtask

  task automatic test_reinit();
    int n;
    int low_cycles;
    n              = 0;
    low_cycles     = 0;
    readout_mask_i = 8'b0000_0001;
    dmode_i        = 1'b1;
    trigger_i      = 1'b0;
    pulse_start();
    // warm-up length is fixed, afterwards the domino runs freely
    repeat (DOMINO_WARMUP_CYCLES + 4) next_cycle();
    check_value("busy_o", busy_o, 1'b1);
    reinit_i = 1'b1;
    next_cycle();
    reinit_i = 1'b0;
    while (drs_nreset_o) begin
      n++;
      if (n > TIMEOUT_CYCLES) begin
        stop_on_error("reinit did not reach the reset state");
      end
      next_cycle();
    end
    while (!drs_nreset_o) begin
      low_cycles++;
      if (low_cycles > TIMEOUT_CYCLES) begin
        stop_on_error("drs_nreset_o stayed low after reinit");
      end
      next_cycle();
    end
    check_value("drs_nreset_o low cycles", low_cycles, RESET_HOLD_CYCLES);
    check_idle_outputs();
  endtask

  initial begin
    rng_state          = 32'hb404fc3b;
    adc_hist[0]        = '0;
    adc_hist[1]        = '0;
    reset              = 1'b1;
    trigger_i          = 1'b0;
    adc_data_i         = '0;
    dmode_i            = 1'b1;
    start_i            = 1'b0;
    reinit_i           = 1'b0;
    configure_i        = 1'b0;
    standby_i          = 1'b0;
    config_i           = '0;
    chn_config_i       = '0;
    wait_vdd_clocks_i  = SETTLE_CLOCKS;
    sample_count_max_i = SAMPLE_MAX;
    adc_latency_i      = ADC_LATENCY;
    readout_mask_i     = '0;
    repeat (4) next_cycle();
    reset = 1'b0;

    test_reset();
    test_configure();
    test_triggered_readout();
    test_single_shot();
    test_zero_mask();
    test_standby();
    test_reinit();

    $display("all tests passed");
    $finish;
  end

endmodule

// ==== flist.f ====
src/drs_pkg.sv
src/drs_if.sv
src/drs_sequencer.sv
src/drs_serializer.sv
src/drs_channel_scan.sv
src/drs_sample_gate.sv
src/drs_readout.sv
test/drs_readout_assert.sv
test/tb_drs_readout.sv

// ==== Makefile ====
OBJ_DIR := obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f flist.f \
		--top-module tb_drs_readout --Mdir $(OBJ_DIR) -o sim
	./$(OBJ_DIR)/sim

clean:
	rm -rf $(OBJ_DIR)
